// File: rtl/eci_bridge_pkg.sv
package eci_bridge_pkg;

    // Bus and link widths
    localparam int ECI_ID_WIDTH      = 5;
    localparam int ECI_ADDR_WIDTH    = 40;
    localparam int ECI_WORD_WIDTH    = 64;
    localparam int ECI_LEN_WIDTH     = 8;

    // One AXI beat maps onto one cache line
    localparam int ECI_CL_SIZE_BYTES = 128;
    localparam int ECI_LINE_LSB      = $clog2(ECI_CL_SIZE_BYTES);
    localparam int ECI_LINE_WIDTH    = ECI_ADDR_WIDTH - ECI_LINE_LSB;

    // Aliasing folds a higher slice of the line index into its low bits
    localparam int ECI_ALIAS_BITS    = 8;
    localparam int ECI_ALIAS_SRC_LSB = 12;

    // Request opcodes on the virtual channel
    typedef enum logic [4:0] {
        ECI_CMD_MREQ_RLDD = 5'b00000,
        ECI_CMD_MREQ_RLDI = 5'b00001,
        ECI_CMD_MREQ_RLDT = 5'b00010
    } eci_opcode_e;

    // AXI read-address request
    typedef struct packed {
        logic [ECI_ID_WIDTH-1:0]   id;
        logic [ECI_ADDR_WIDTH-1:0] addr;
        logic [ECI_LEN_WIDTH-1:0]  len;
    } ar_req_t;

    // One cache-line request, line index not yet aliased
    typedef struct packed {
        logic [ECI_ID_WIDTH-1:0]   id;
        logic [ECI_LINE_WIDTH-1:0] line;
    } line_beat_t;

    // Read-line command word, MSB first
    typedef struct packed {
        eci_opcode_e               opcode;
        logic [ECI_ID_WIDTH-1:0]   rreq_id;
        logic [3:0]                dmask;
        logic                      ns;
        logic [15:0]               reserved;
        logic [ECI_LINE_WIDTH-1:0] address;
    } eci_rldt_t;

    // Low byte of the line index XORed with line bits 19:12
    function automatic logic [ECI_LINE_WIDTH-1:0] eci_alias_line(
        input logic [ECI_LINE_WIDTH-1:0] line
    );
        logic [ECI_LINE_WIDTH-1:0] aliased;

        aliased = line;
        aliased[ECI_ALIAS_BITS-1:0] = line[ECI_ALIAS_BITS-1:0]
                                    ^ line[ECI_ALIAS_SRC_LSB +: ECI_ALIAS_BITS];
        return aliased;
    endfunction

endpackage

// File: rtl/ar_burst_splitter.sv
module ar_burst_splitter import eci_bridge_pkg::*; (
    input  logic       aclk,
    input  logic       aresetn,

    // AXI read-address channel
    input  ar_req_t    ar,
    input  logic       ar_valid,
    output logic       ar_ready,

    // One line request per beat
    output line_beat_t beat,
    output logic       beat_valid,
    input  logic       beat_ready
);

    typedef enum logic {
        ST_IDLE,
        ST_BURST
    } split_state_e;

    split_state_e              state;
    logic [ECI_ID_WIDTH-1:0]   id_q;
    logic [ECI_LINE_WIDTH-1:0] line_q;
    logic [ECI_LEN_WIDTH-1:0]  remaining_q;

    logic ar_fire;
    logic beat_fire;
    logic last_beat;

    // New requests only between bursts
    assign ar_ready   = (state == ST_IDLE);
    assign beat_valid = (state == ST_BURST);

    assign ar_fire   = ar_valid & ar_ready;
    assign beat_fire = beat_valid & beat_ready;
    assign last_beat = (remaining_q == '0);

    assign beat.id   = id_q;
    assign beat.line = line_q;

    // Control state
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state       <= ST_IDLE;
            remaining_q <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (ar_fire) begin
                        state       <= ST_BURST;
                        remaining_q <= ar.len;
                    end
                end
                ST_BURST: begin
                    if (beat_fire) begin
                        if (last_beat) begin
                            state <= ST_IDLE;
                        end else begin
                            remaining_q <= remaining_q - 1'b1;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Burst payload, id held and line index stepping one per beat
    always_ff @(posedge aclk) begin
        if (ar_fire) begin
            id_q   <= ar.id;
            line_q <= ar.addr[ECI_ADDR_WIDTH-1:ECI_LINE_LSB];
        end else if (beat_fire && !last_beat) begin
            line_q <= line_q + 1'b1;
        end
    end

endmodule

// File: rtl/rd_cmd_encoder.sv
module rd_cmd_encoder import eci_bridge_pkg::*; (
    input  logic       aclk,
    input  logic       aresetn,

    // Line requests from the splitter
    input  line_beat_t beat,
    input  logic       beat_valid,
    output logic       beat_ready,

    // Packed read-line commands toward the FIFO
    output eci_rldt_t  cmd,
    output logic       cmd_valid,
    input  logic       cmd_ready
);

    logic       advance;

    line_beat_t s1_beat;
    logic       s1_valid;

    eci_rldt_t  cmd_next;
    eci_rldt_t  cmd_q;
    logic       cmd_valid_q;

    // Whole pipeline moves as one, frozen while downstream is full
    assign advance    = cmd_ready;
    assign beat_ready = cmd_ready;

    // Stage one valid
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            s1_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= beat_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (advance) begin
            s1_beat <= beat;
        end
    end

    // Build the command between the two stages
    always_comb begin
        cmd_next.opcode   = ECI_CMD_MREQ_RLDT;
        cmd_next.rreq_id  = s1_beat.id;
        // Whole line requested, non-secure access
        cmd_next.dmask    = '1;
        cmd_next.ns       = 1'b1;
        cmd_next.reserved = '0;
        cmd_next.address  = eci_alias_line(s1_beat.line);
    end

    // Stage two valid
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            cmd_valid_q <= 1'b0;
        end else if (advance) begin
            cmd_valid_q <= s1_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (advance) begin
            cmd_q <= cmd_next;
        end
    end

    assign cmd       = cmd_q;
    assign cmd_valid = cmd_valid_q;

endmodule

// File: rtl/vc_fifo.sv
module vc_fifo import eci_bridge_pkg::*; #(
    parameter int DEPTH = 8
) (
    input  logic                      aclk,
    input  logic                      aresetn,

    // Write side
    input  eci_rldt_t                 in_data,
    input  logic                      in_valid,
    output logic                      in_ready,

    // Virtual-channel side
    output logic [ECI_WORD_WIDTH-1:0] out_data,
    output logic                      out_valid,
    input  logic                      out_ready
);

    localparam int               PTR_W      = $clog2(DEPTH);
    localparam logic [PTR_W:0]   FULL_COUNT = (PTR_W + 1)'(DEPTH);

    eci_rldt_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    logic full;
    logic wr_en;
    logic rd_en;

    assign full      = (count == FULL_COUNT);
    assign out_valid = (count != '0);

    // A full FIFO still takes a word when one leaves in the same cycle
    assign in_ready  = ~full | out_ready;

    assign wr_en = in_valid & in_ready;
    assign rd_en = out_valid & out_ready;

    assign out_data = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

// File: rtl/axi_eci_rd_req.sv
module axi_eci_rd_req import eci_bridge_pkg::*; #(
    parameter int VC_FIFO_DEPTH = 8
) (
    input  logic                      aclk,
    input  logic                      aresetn,

    // AXI read-address channel
    input  ar_req_t                   ar,
    input  logic                      ar_valid,
    output logic                      ar_ready,

    // Virtual channel toward the CPU
    output logic [ECI_WORD_WIDTH-1:0] vc_data,
    output logic                      vc_valid,
    input  logic                      vc_ready
);

    line_beat_t beat;
    logic       beat_valid;
    logic       beat_ready;

    eci_rldt_t  cmd;
    logic       cmd_valid;
    logic       cmd_ready;

    // Bursts into single line requests
    ar_burst_splitter u_splitter (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .ar         (ar),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .beat       (beat),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready)
    );

    // Alias and pack
    rd_cmd_encoder u_encoder (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .beat       (beat),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready)
    );

    vc_fifo #(
        .DEPTH (VC_FIFO_DEPTH)
    ) u_vc_fifo (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_data   (cmd),
        .in_valid  (cmd_valid),
        .in_ready  (cmd_ready),
        .out_data  (vc_data),
        .out_valid (vc_valid),
        .out_ready (vc_ready)
    );

endmodule

// File: dv/tb_axi_eci_rd_req.sv
module tb_axi_eci_rd_req import eci_bridge_pkg::*; ();

    localparam int CLK_PERIOD  = 10;
    localparam int RANDOM_REQS = 200;
    localparam int B2B_REQS    = 8;
    localparam int MAX_LEN     = 8;

    // Worst case beat count over every phase sets the watchdog
    localparam int MAX_BEATS      = 1 + 16 + B2B_REQS * MAX_LEN + 2 * RANDOM_REQS * MAX_LEN;
    localparam int TIMEOUT_CYCLES = MAX_BEATS * 40 + 1000;

    logic                      aclk;
    logic                      aresetn;
    ar_req_t                   ar;
    logic                      ar_valid;
    logic                      ar_ready;
    logic [ECI_WORD_WIDTH-1:0] vc_data;
    logic                      vc_valid;
    logic                      vc_ready;

    logic [ECI_WORD_WIDTH-1:0] exp_q[$];
    int                        errors;
    int                        words_checked;
    int                        reqs_sent;
    int                        ar_busy;
    bit                        ready_random;

    axi_eci_rd_req #(
        .VC_FIFO_DEPTH (8)
    ) u_axi_eci_rd_req (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .vc_data  (vc_data),
        .vc_valid (vc_valid),
        .vc_ready (vc_ready)
    );

    initial aclk = 1'b0;
    always #(CLK_PERIOD / 2) aclk = ~aclk;

    // Expected command word for one line
    function automatic logic [ECI_WORD_WIDTH-1:0] expected_word(
        input logic [ECI_ID_WIDTH-1:0]   id,
        input logic [ECI_LINE_WIDTH-1:0] line
    );
        logic [ECI_LINE_WIDTH-1:0] aliased;

        aliased = line;
        aliased[7:0] = line[7:0] ^ line[19:12];
        return {ECI_CMD_MREQ_RLDT, id, 4'hf, 1'b1, 16'h0000, aliased};
    endfunction

    task automatic check_value(
        input string                     name,
        input logic [ECI_WORD_WIDTH-1:0] expected,
        input logic [ECI_WORD_WIDTH-1:0] actual
    );
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR %s at %0t", msg, $time);
    endtask

    // Called on a falling edge, returns on the falling edge after the AR transfer
    task automatic send_request(
        input logic [ECI_ID_WIDTH-1:0]   id,
        input logic [ECI_ADDR_WIDTH-1:0] addr,
        input logic [ECI_LEN_WIDTH-1:0]  len
    );
        logic [ECI_LINE_WIDTH-1:0] line;

        line = addr[ECI_ADDR_WIDTH-1:ECI_LINE_LSB];
        for (int i = 0; i <= int'(len); i++) begin
            exp_q.push_back(expected_word(id, line));
            line = line + ECI_LINE_WIDTH'(1);
        end
        ar.id    = id;
        ar.addr  = addr;
        ar.len   = len;
        ar_valid = 1'b1;
        reqs_sent++;
        while (!ar_ready) begin
            @(negedge aclk);
        end
        @(negedge aclk);
        ar_valid = 1'b0;
    endtask

    task automatic send_random_request(input int max_gap);
        logic [ECI_ADDR_WIDTH-1:0] addr;

        addr = {8'($urandom), $urandom};
        send_request(ECI_ID_WIDTH'($urandom), addr, ECI_LEN_WIDTH'($urandom % MAX_LEN));
        if (max_gap > 0) begin
            repeat ($urandom % (max_gap + 1)) @(negedge aclk);
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge aclk);
        end
        // Extra cycles catch words nobody asked for
        repeat (8) @(negedge aclk);
    endtask

    // Output compare, values taken before the edge updates them
    always @(posedge aclk) begin
        if (aresetn && vc_valid && vc_ready) begin
            if (exp_q.size() == 0) begin
                report_error("word on vc_data while no command was expected");
            end else begin
                check_value("vc_data", exp_q.pop_front(), vc_data);
                words_checked++;
            end
        end
    end

    // Splitter stays busy for at least one cycle per beat of the accepted burst
    always @(posedge aclk) begin
        if (aresetn) begin
            if (ar_busy > 0) begin
                if (ar_ready) begin
                    report_error("ar_ready high while a burst was still being split");
                end
                ar_busy--;
            end
            if (ar_valid && ar_ready) begin
                ar_busy = int'(ar.len) + 1;
            end
        end
    end

    // Random back-pressure, roughly 40 percent low
    always @(negedge aclk) begin
        if (ready_random) begin
            vc_ready = (($urandom % 10) >= 4);
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, the DUT stopped producing words", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int base;

        void'($urandom(32'hb9c5_c4e7));
        errors        = 0;
        words_checked = 0;
        reqs_sent     = 0;
        ar_busy       = 0;
        ready_random  = 1'b0;
        aresetn       = 1'b0;
        ar            = '0;
        ar_valid      = 1'b0;
        vc_ready      = 1'b0;

        // Outputs quiet through reset and idle time
        repeat (3) begin
            @(negedge aclk);
            check_value("vc_valid", 64'(0), 64'(vc_valid));
        end
        aresetn  = 1'b1;
        vc_ready = 1'b1;
        check_value("ar_ready", 64'(1), 64'(ar_ready));
        repeat (4) begin
            @(negedge aclk);
            check_value("vc_valid", 64'(0), 64'(vc_valid));
        end

        // Single beat
        base = words_checked;
        send_request(5'h0b, 40'h12_3456_7880, 8'd0);
        wait_drain();
        check_value("single beat word count", 64'(1), 64'(words_checked - base));

        // Line 0x30ff8 upward, alias key moves from 0x30 to 0x31 halfway
        base = words_checked;
        send_request(5'h1c, 40'h00_0187_fc00, 8'd15);
        wait_drain();
        check_value("boundary burst word count", 64'(16), 64'(words_checked - base));

        // Random traffic, no back-pressure
        repeat (RANDOM_REQS) send_random_request(2);
        wait_drain();

        // Random traffic under back-pressure
        ready_random = 1'b1;
        repeat (RANDOM_REQS) send_random_request(2);
        wait_drain();
        ready_random = 1'b0;
        @(negedge aclk);
        vc_ready = 1'b1;

        // Next request waits at the port while the previous burst drains
        repeat (B2B_REQS) send_random_request(0);
        wait_drain();

        if (exp_q.size() != 0) begin
            report_error($sformatf("%0d expected words never arrived", exp_q.size()));
        end

        $display("Checked %0d words from %0d requests, %0d errors", words_checked, reqs_sent,
                 errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
rtl/eci_bridge_pkg.sv
rtl/ar_burst_splitter.sv
rtl/rd_cmd_encoder.sv
rtl/vc_fifo.sv
rtl/axi_eci_rd_req.sv
dv/tb_axi_eci_rd_req.sv

// File: Makefile
TOP  = tb_axi_eci_rd_req
SRCS = $(shell grep -v '^+' sources.f)

.PHONY: all run clean

all: run

obj_dir/V$(TOP): sources.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sources.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
